// ==== synth_pkg.sv ====
package synth_pkg;

    // 0..11 are C through B, 12 and up is a rest
    typedef logic [3:0] note_t;

    localparam note_t note_rest = 4'd12;

    typedef struct packed
    {
        logic [2:0] octave;
        note_t      note;
    } voice_setting_t;

    localparam voice_setting_t setting_rest = '{octave: 3'd0, note: note_rest};

    typedef struct packed
    {
        logic           voice_sel;  // 0 melody, 1 bass
        voice_setting_t setting;
    } note_cmd_t;

    localparam int phase_width = 8;

    // Last phase of one period at octave 0, one frame per phase
    localparam logic [phase_width-1:0] period_table [12] = '{
        8'd183, 8'd173, 8'd163, 8'd154, 8'd145, 8'd137,
        8'd129, 8'd122, 8'd115, 8'd108, 8'd102, 8'd96
    };

    localparam logic signed [15:0] tone_amplitude = 16'sh2000;

    // Active low abcdefgh, sharps light the h segment
    localparam logic [7:0] segment_table [12] = '{
        8'b01100011, 8'b01100010, 8'b10000101, 8'b10000100,
        8'b01100001, 8'b01110001, 8'b01110000, 8'b01000011,
        8'b01000010, 8'b00010001, 8'b00010000, 8'b11000001
    };

    localparam logic [7:0] segment_blank = 8'b1111_1111;

endpackage

// ==== i2s_pkg.sv ====
package i2s_pkg;

    // 50 MHz system clock divided down by a free running counter
    localparam int div_width = 10;

    localparam int mclk_tap  = 1;   // 12.5 MHz
    localparam int bclk_tap  = 3;   // 3.125 MHz
    localparam int lrclk_tap = 9;   // About 48.8 kHz

    // 32 bit clocks per channel, sample in the top bits
    localparam int slot_width   = 32;
    localparam int sample_width = 16;

endpackage

// ==== square_tone.sv ====
module square_tone
    import synth_pkg::*;
    import i2s_pkg::*;
(
    input  voice_setting_t                 setting,
    input  logic [phase_width-1:0]         phase,
    output logic [phase_width-1:0]         last_phase,
    output logic signed [sample_width-1:0] sample
);

    always_comb
    begin
        if (setting.note < note_rest)
        begin
            // Each octave up halves the period
            last_phase = period_table[setting.note] >> setting.octave;

            if (phase <= (last_phase >> 1))  // High half of the period
                sample = tone_amplitude;
            else
                sample = -tone_amplitude;
        end
        else
        begin
            last_phase = '0;
            sample     = '0;
        end
    end

endmodule

// ==== tone_voice.sv ====
module tone_voice
    import synth_pkg::*;
    import i2s_pkg::*;
(
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           frame_tick,
    input  voice_setting_t                 setting,
    output logic signed [sample_width-1:0] sample
);

    logic [phase_width-1:0] phase;
    logic [phase_width-1:0] last_phase;
    voice_setting_t         prev_setting;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            phase        <= '0;
            prev_setting <= setting_rest;
        end
        else if (frame_tick)
        begin
            prev_setting <= setting;

            if (setting != prev_setting)     // New note starts its period
                phase <= '0;
            else if (phase >= last_phase)
                phase <= '0;
            else
                phase <= phase + 1'b1;
        end
    end

    square_tone u_square_tone
    (
        .setting    ( setting    ),
        .phase      ( phase      ),
        .last_phase ( last_phase ),
        .sample     ( sample     )
    );

endmodule

// ==== voice_control.sv ====
module voice_control
    import synth_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  logic           frame_tick,
    input  note_cmd_t      cmd,
    input  logic           cmd_valid,
    output logic           cmd_ready,
    output voice_setting_t melody_setting,
    output voice_setting_t bass_setting
);

    note_cmd_t pending;
    logic      pending_valid;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            pending_valid  <= 1'b0;
            cmd_ready      <= 1'b0;
            melody_setting <= setting_rest;
            bass_setting   <= setting_rest;
        end
        else
        begin
            if (cmd_valid && cmd_ready)
            begin
                pending_valid <= 1'b1;
                cmd_ready     <= 1'b0;
            end
            else if (frame_tick && pending_valid)
            begin
                // Voices only change on a frame boundary
                pending_valid <= 1'b0;
                cmd_ready     <= 1'b1;

                if (pending.voice_sel)
                    bass_setting <= pending.setting;
                else
                    melody_setting <= pending.setting;
            end
            else
            begin
                cmd_ready <= !pending_valid;  // Rises once out of reset
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (cmd_valid && cmd_ready)
            pending <= cmd;
    end

endmodule

// ==== voice_mixer.sv ====
module voice_mixer
    import i2s_pkg::*;
(
    input  logic                           clk,
    input  logic                           reset,
    input  logic signed [sample_width-1:0] melody_sample,
    input  logic signed [sample_width-1:0] bass_sample,
    output logic signed [sample_width-1:0] mixed
);

    // Each voice stays within 0x2000, so the sum fits in 16 bits
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            mixed <= '0;
        else
            mixed <= melody_sample + bass_sample;
    end

endmodule

// ==== i2s_serializer.sv ====
module i2s_serializer
    import i2s_pkg::*;
(
    input  logic                           clk,
    input  logic                           reset,
    input  logic signed [sample_width-1:0] sample,
    output logic                           mclk,
    output logic                           bclk,
    output logic                           lrclk,
    output logic                           sdata,
    output logic                           frame_tick
);

    logic [div_width-1:0]  clk_div;
    logic [slot_width-1:0] slot;
    logic                  bit_end;
    logic                  slot_start;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            clk_div <= '0;
        else
            clk_div <= clk_div + 1'b1;
    end

    assign mclk  = clk_div[mclk_tap];
    assign bclk  = clk_div[bclk_tap];
    assign lrclk = clk_div[lrclk_tap];    // Low is left

    // High for the first cycle of each frame
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            frame_tick <= 1'b0;
        else
            frame_tick <= &clk_div;
    end

    assign bit_end = &clk_div[bclk_tap:0];  // Falling edge of bclk

    // First bit of each half frame, MSB goes out one bclk after lrclk
    assign slot_start = bit_end && (clk_div[lrclk_tap-1:bclk_tap+1] == '0);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            slot <= '0;
        else if (slot_start)
            slot <= {sample, {(slot_width - sample_width){1'b0}}};
        else if (bit_end)
            slot <= slot << 1;
    end

    assign sdata = slot[slot_width-1];

endmodule

// ==== note_display.sv ====
module note_display
    import synth_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  voice_setting_t setting,
    output logic [7:0]     abcdefgh
);

    // Octave is not shown, only the note name
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            abcdefgh <= segment_blank;
        else if (setting.note < note_rest)
            abcdefgh <= segment_table[setting.note];
        else
            abcdefgh <= segment_blank;
    end

endmodule

// ==== synth_top.sv ====
module synth_top
    import synth_pkg::*;
    import i2s_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  note_cmd_t  cmd,
    input  logic       cmd_valid,
    output logic       cmd_ready,
    output logic       mclk,
    output logic       bclk,
    output logic       lrclk,
    output logic       sdata,
    output logic [7:0] abcdefgh
);

    logic                           frame_tick;
    voice_setting_t                 melody_setting;
    voice_setting_t                 bass_setting;
    logic signed [sample_width-1:0] melody_sample;
    logic signed [sample_width-1:0] bass_sample;
    logic signed [sample_width-1:0] mixed;

    voice_control u_voice_control
    (
        .clk            ( clk            ),
        .reset          ( reset          ),
        .frame_tick     ( frame_tick     ),
        .cmd            ( cmd            ),
        .cmd_valid      ( cmd_valid      ),
        .cmd_ready      ( cmd_ready      ),
        .melody_setting ( melody_setting ),
        .bass_setting   ( bass_setting   )
    );

    tone_voice u_melody
    (
        .clk        ( clk            ),
        .reset      ( reset          ),
        .frame_tick ( frame_tick     ),
        .setting    ( melody_setting ),
        .sample     ( melody_sample  )
    );

    tone_voice u_bass
    (
        .clk        ( clk          ),
        .reset      ( reset        ),
        .frame_tick ( frame_tick   ),
        .setting    ( bass_setting ),
        .sample     ( bass_sample  )
    );

    voice_mixer u_voice_mixer
    (
        .clk           ( clk           ),
        .reset         ( reset         ),
        .melody_sample ( melody_sample ),
        .bass_sample   ( bass_sample   ),
        .mixed         ( mixed         )
    );

    // Same mixed sample on both channels
    i2s_serializer u_i2s_serializer
    (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .sample     ( mixed      ),
        .mclk       ( mclk       ),
        .bclk       ( bclk       ),
        .lrclk      ( lrclk      ),
        .sdata      ( sdata      ),
        .frame_tick ( frame_tick )
    );

    note_display u_note_display
    (
        .clk      ( clk            ),
        .reset    ( reset          ),
        .setting  ( melody_setting ),
        .abcdefgh ( abcdefgh       )
    );

endmodule

// ==== tb_synth_top.sv ====
module tb_synth_top
    import synth_pkg::*;
    import i2s_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    // Tests take under 800 frames of 1024 cycles
    localparam int cycle_limit = 1_200_000;

    logic       clk = 1'b0;
    logic       reset;
    note_cmd_t  cmd;
    logic       cmd_valid;
    logic       cmd_ready;
    logic       mclk;
    logic       bclk;
    logic       lrclk;
    logic       sdata;
    logic [7:0] abcdefgh;

    int    seed = 6;
    int    cycle_count = 0;
    int    test_errors;
    int    pass_count = 0;
    int    fail_count = 0;
    string test_name;

    logic [slot_width-1:0] rx_word = '0;
    logic [slot_width-1:0] rx_left = '0;
    logic                  rx_lr = 1'b0;
    logic [slot_width-1:0] left_q [$];
    logic [slot_width-1:0] right_q [$];

    synth_top u_synth_top
    (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .cmd       ( cmd       ),
        .cmd_valid ( cmd_valid ),
        .cmd_ready ( cmd_ready ),
        .mclk      ( mclk      ),
        .bclk      ( bclk      ),
        .lrclk     ( lrclk     ),
        .sdata     ( sdata     ),
        .abcdefgh  ( abcdefgh  )
    );

    always #2 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= cycle_limit)
        begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // Last bit of a slot arrives after the lrclk change
    always @(posedge bclk)
    begin
        if (lrclk != rx_lr)
        begin
            if (rx_lr)
            begin
                left_q.push_back(rx_left);
                right_q.push_back({rx_word[slot_width-2:0], sdata});
            end
            else
                rx_left = {rx_word[slot_width-2:0], sdata};
            rx_word = '0;
            rx_lr   = lrclk;
        end
        else
            rx_word = {rx_word[slot_width-2:0], sdata};
    end

    function automatic note_cmd_t make_cmd(input logic sel, input voice_setting_t s);
        note_cmd_t c;
        c.voice_sel = sel;
        c.setting   = s;
        return c;
    endfunction

    function automatic int last_phase_of(input voice_setting_t s);
        if (s.note >= note_rest)
            return 0;
        return period_table[s.note] >> s.octave;
    endfunction

    function automatic int tone_sample(input voice_setting_t s, input int phase);
        if (s.note >= note_rest)
            return 0;
        if (phase <= last_phase_of(s) / 2)  // First half plus the middle phase
            return int'(tone_amplitude);
        return -int'(tone_amplitude);
    endfunction

    function automatic logic clock_output(input int sel);
        case (sel)
            0:       return mclk;
            1:       return bclk;
            default: return lrclk;
        endcase
    endfunction

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        if (test_errors == 0)
        begin
            $display("%s: passed", test_name);
            pass_count++;
        end
        else
        begin
            $display("%s: failed with %0d errors", test_name, test_errors);
            fail_count++;
        end
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        assert (actual == expected)
        else
        begin
            $display("FAILED %s: %s expected %0d, actual %0d",
                     test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic verify_half_period(input string what, input int sel, input int expected);
        logic prev;
        int   count;
        prev = clock_output(sel);
        while (clock_output(sel) == prev)
        begin
            @(posedge clk);
            #1;
        end
        prev  = clock_output(sel);
        count = 0;
        while (clock_output(sel) == prev)
        begin
            @(posedge clk);
            #1;
            count++;
        end
        check_value(what, expected, count);
    endtask

    task automatic send_cmd(input note_cmd_t c, input bit hold_valid, output int waited);
        bit ready_seen;
        bit accepted;
        cmd       = c;
        cmd_valid = 1'b1;
        accepted  = 1'b0;
        waited    = 0;
        while (!accepted)
        begin
            ready_seen = cmd_ready;  // Value at the coming edge
            @(posedge clk);
            #1;
            waited++;
            accepted = ready_seen;
        end
        if (!hold_valid)
            cmd_valid = 1'b0;
    endtask

    // cmd_ready returns right after the tick that applied the command
    task automatic wait_applied(output int waited);
        waited = 0;
        do
        begin
            @(posedge clk);
            #1;
            waited++;
        end
        while (!cmd_ready);
    endtask

    task automatic next_frame(output logic [slot_width-1:0] left,
                              output logic [slot_width-1:0] right);
        while (right_q.size() == 0)
        begin
            @(posedge clk);
            #1;
        end
        left  = left_q.pop_front();
        right = right_q.pop_front();
    endtask

    // Drops the frame before the tick and the frame of the tick itself
    task automatic align_frames();
        logic [slot_width-1:0] l;
        logic [slot_width-1:0] r;
        left_q.delete();
        right_q.delete();
        next_frame(l, r);
        next_frame(l, r);
    endtask

    // Ticks count from the apply tick to the start of the first checked frame
    task automatic check_frames(input voice_setting_t mel, input int mel_ticks,
                                input voice_setting_t bass, input int bass_ticks,
                                input int count);
        logic [slot_width-1:0] l;
        logic [slot_width-1:0] r;
        int                    expected;
        int                    mp;
        int                    bp;
        for (int i = 0; i < count; i++)
        begin
            next_frame(l, r);
            mp = (mel_ticks + i - 1) % (last_phase_of(mel) + 1);
            bp = (bass_ticks + i - 1) % (last_phase_of(bass) + 1);
            expected = tone_sample(mel, mp) + tone_sample(bass, bp);
            check_value("left sample", expected, $signed(l[slot_width-1 -: sample_width]));
            check_value("left padding", 0, l[slot_width-sample_width-1:0]);
            check_value("right slot", l, r);
        end
    endtask

    task automatic reset_and_idle();
        int count;
        start_test("reset_idle");
        repeat (16)
        begin
            @(posedge clk);
            #1;
            check_value("cmd_ready in reset", 0, cmd_ready);
            check_value("clocks in reset", 0, {mclk, bclk, lrclk});
            check_value("sdata in reset", 0, sdata);
            check_value("display in reset", segment_blank, abcdefgh);
        end
        reset = 1'b0;
        wait_applied(count);
        check_frames(setting_rest, 1, setting_rest, 1, 3);
        verify_half_period("mclk half period", 0, 1 << mclk_tap);
        verify_half_period("bclk half period", 1, 1 << bclk_tap);
        for (int h = 0; h < 2; h++)
            verify_half_period("lrclk half period", 2, 1 << lrclk_tap);
        finish_test();
    endtask

    task automatic play_single_tone();
        voice_setting_t mel;
        int             waited;
        start_test("single_tone");
        mel = '{octave: 3'd1, note: 4'd9};  // A at 55 frames per period
        send_cmd(make_cmd(1'b0, mel), 1'b0, waited);
        wait_applied(waited);
        align_frames();
        check_value("display", segment_table[9], abcdefgh);
        check_frames(mel, 1, setting_rest, 1, 112);
        finish_test();
    endtask

    task automatic pick_setting(input voice_setting_t avoid, output voice_setting_t s);
        do
        begin
            s.note   = note_t'($unsigned($random(seed)) % 12);
            s.octave = 3'($unsigned($random(seed)) % 8);
        end
        while (s == avoid);  // A repeated setting would not restart the phase
    endtask

    task automatic mix_two_voices();
        voice_setting_t mel;
        voice_setting_t bass;
        int             waited;
        int             applied;
        start_test("two_voices");
        mel  = '{octave: 3'd1, note: 4'd9};
        bass = setting_rest;
        for (int round = 0; round < 3; round++)
        begin
            pick_setting(mel, mel);
            pick_setting(bass, bass);
            send_cmd(make_cmd(1'b0, mel), 1'b0, waited);
            wait_applied(applied);
            send_cmd(make_cmd(1'b1, bass), 1'b0, waited);
            wait_applied(applied);
            check_value("cycles between voice updates", 1024, waited + applied);
            align_frames();
            check_frames(mel, 2, bass, 1, 60);
        end
        finish_test();
    endtask

    task automatic rest_both_voices();
        voice_setting_t rest;
        int             waited;
        start_test("rest");
        rest = '{octave: 3'd0, note: 4'd13};
        send_cmd(make_cmd(1'b0, rest), 1'b0, waited);
        wait_applied(waited);
        @(posedge clk);
        #1;
        check_value("display", segment_blank, abcdefgh);
        send_cmd(make_cmd(1'b1, rest), 1'b0, waited);
        wait_applied(waited);
        align_frames();
        check_frames(rest, 2, rest, 1, 8);
        finish_test();
    endtask

    task automatic hold_back_to_back();
        voice_setting_t mel;
        voice_setting_t bass;
        int             waited;
        start_test("back_pressure");
        mel  = '{octave: 3'd2, note: 4'd4};
        bass = '{octave: 3'd1, note: 4'd7};
        send_cmd(make_cmd(1'b0, mel), 1'b1, waited);
        check_value("cmd_ready after first accept", 0, cmd_ready);
        send_cmd(make_cmd(1'b1, bass), 1'b0, waited);
        assert (waited >= 2 && waited <= 1025)
        else
        begin
            $display("FAILED %s: second accept wait expected 2 to 1025 cycles, actual %0d",
                     test_name, waited);
            test_errors++;
        end
        check_value("display at second accept", segment_table[4], abcdefgh);
        wait_applied(waited);
        check_value("bass apply wait", 1023, waited);
        align_frames();
        check_frames(mel, 2, bass, 1, 60);
        finish_test();
    endtask

    task automatic step_display_notes();
        int waited;
        start_test("display");
        for (int n = 0; n < 12; n++)
        begin
            send_cmd(make_cmd(1'b0, '{octave: 3'(n % 4), note: note_t'(n)}), 1'b0, waited);
            wait_applied(waited);
            @(posedge clk);  // Display is one register behind the melody
            #1;
            check_value($sformatf("segments of note %0d", n), segment_table[n], abcdefgh);
        end
        finish_test();
    endtask

    initial
    begin
        reset     = 1'b1;
        cmd       = '0;
        cmd_valid = 1'b0;

        reset_and_idle();
        play_single_tone();
        mix_two_voices();
        rest_both_voices();
        hold_back_to_back();
        step_display_notes();

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== verilog.f ====
synth_pkg.sv
i2s_pkg.sv
square_tone.sv
tone_voice.sv
voice_control.sv
voice_mixer.sv
i2s_serializer.sv
note_display.sv
synth_top.sv
tb_synth_top.sv

// ==== Bender.yml ====
package:
  name: synth_top

sources:
  - files:
      - synth_pkg.sv
      - i2s_pkg.sv
      - square_tone.sv
      - tone_voice.sv
      - voice_control.sv
      - voice_mixer.sv
      - i2s_serializer.sv
      - note_display.sv
      - synth_top.sv
  - target: simulation
    files:
      - tb_synth_top.sv
